// File: logic/core_pkg.sv
package core_pkg;

    // Architectural widths
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = 5;
    localparam int CSR_AW   = 14;
    localparam int ECODE_W  = 6;
    localparam int NUM_HWI  = 8;   // External interrupt lines

    localparam logic [ECODE_W-1:0] ECODE_INT = '0;

    // Implemented CSRs with all other addresses reading zero
    typedef enum logic [CSR_AW-1:0] {
        CSR_CRMD   = 14'h0,
        CSR_PRMD   = 14'h1,
        CSR_ECFG   = 14'h4,
        CSR_ESTAT  = 14'h5,
        CSR_ERA    = 14'h6,
        CSR_EENTRY = 14'hc,
        CSR_SAVE0  = 14'h30,
        CSR_SAVE1  = 14'h31,
        CSR_SAVE2  = 14'h32,
        CSR_SAVE3  = 14'h33
    } csr_addr_e;

    typedef enum logic [2:0] {
        OP_ALU   = 3'd0,  // rd <= wdata
        OP_CSRRD = 3'd1,  // rd <= csr
        OP_CSRWR = 3'd2,  // csr <= wdata, rd <= old csr
        OP_EXCP  = 3'd3,
        OP_ERTN  = 3'd4
    } commit_op_e;

    // One retiring instruction
    typedef struct packed {
        logic               valid;
        logic [XLEN-1:0]    pc;
        commit_op_e         op;
        logic [REG_AW-1:0]  rd;
        logic [XLEN-1:0]    wdata;
        logic [CSR_AW-1:0]  csr_addr;
        logic [ECODE_W-1:0] ecode;
    } commit_slot_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } rf_write_t;

    typedef struct packed {
        logic              re;
        logic              we;
        logic [CSR_AW-1:0] addr;
        logic [XLEN-1:0]   wdata;
    } csr_access_t;

    // At most one of excp and ertn per cycle
    typedef struct packed {
        logic               excp;
        logic               ertn;
        logic [XLEN-1:0]    pc;
        logic [ECODE_W-1:0] ecode;
    } excp_event_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic              wen;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
    } trace_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage

// File: logic/regfile.sv
`timescale 1ns/1ps

module regfile
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  rf_write_t         wr0_i,
    input  rf_write_t         wr1_i,
    input  logic [REG_AW-1:0] raddr_i,
    output logic [XLEN-1:0]   rdata_o
);

    logic [XLEN-1:0] regs [1:NUM_REGS-1];  // No storage for r0

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0_i.we && wr0_i.waddr != '0) begin
                regs[wr0_i.waddr] <= wr0_i.wdata;
            end
            // Port 1 is the younger slot and is assigned last to win
            if (wr1_i.we && wr1_i.waddr != '0) begin
                regs[wr1_i.waddr] <= wr1_i.wdata;
            end
        end
    end

    // Dispatch-side read that sees only earlier edges
    always_comb begin
        if (raddr_i == '0) begin
            rdata_o = '0;
        end else begin
            rdata_o = regs[raddr_i];
        end
    end

endmodule

// File: logic/csr_file.sv
`timescale 1ns/1ps

module csr_file
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  csr_access_t        acc0_i,
    input  csr_access_t        acc1_i,
    input  excp_event_t        event_i,
    input  logic [NUM_HWI-1:0] intrpt_i,
    output logic [XLEN-1:0]    rdata0_o,
    output logic [XLEN-1:0]    rdata1_o,
    output logic [XLEN-1:0]    eentry_o,
    output logic [XLEN-1:0]    era_o,
    output logic               has_int_o
);

    // Only the implemented fields are stored
    typedef struct packed {
        logic [1:0]           plv;     // CRMD
        logic                 ie;
        logic [1:0]           pplv;    // PRMD
        logic                 pie;
        logic [9:0]           lie;     // ECFG
        logic [NUM_HWI-1:0]   is_hw;   // ESTAT.IS[9:2]
        logic [1:0]           is_sw;   // ESTAT.IS[1:0]
        logic [ECODE_W-1:0]   ecode;
        logic [XLEN-1:0]      era;
        logic [XLEN-7:0]      eentry;  // Bits [31:6]
        logic [3:0][XLEN-1:0] save;
    } csr_state_t;

    csr_state_t csr_q;
    csr_state_t csr_wr;   // After both slot writes
    csr_state_t csr_d;

    function automatic logic [XLEN-1:0] csr_read(csr_state_t s, logic [CSR_AW-1:0] addr);
        logic [XLEN-1:0] data;
        case (addr)
            CSR_CRMD:   data = {29'b0, s.ie, s.plv};
            CSR_PRMD:   data = {29'b0, s.pie, s.pplv};
            CSR_ECFG:   data = {22'b0, s.lie};
            CSR_ESTAT:  data = {10'b0, s.ecode, 6'b0, s.is_hw, s.is_sw};
            CSR_ERA:    data = s.era;
            CSR_EENTRY: data = {s.eentry, 6'b0};
            CSR_SAVE0:  data = s.save[0];
            CSR_SAVE1:  data = s.save[1];
            CSR_SAVE2:  data = s.save[2];
            CSR_SAVE3:  data = s.save[3];
            default:    data = '0;
        endcase
        return data;
    endfunction

    function automatic csr_state_t csr_write(csr_state_t s, csr_access_t acc);
        csr_state_t n;
        n = s;
        if (acc.we) begin
            case (acc.addr)
                CSR_CRMD: begin
                    n.plv = acc.wdata[1:0];
                    n.ie  = acc.wdata[2];
                end
                CSR_PRMD: begin
                    n.pplv = acc.wdata[1:0];
                    n.pie  = acc.wdata[2];
                end
                CSR_ECFG:   n.lie     = acc.wdata[9:0];
                CSR_ESTAT:  n.is_sw   = acc.wdata[1:0];  // Ecode and hw lines read-only
                CSR_ERA:    n.era     = acc.wdata;
                CSR_EENTRY: n.eentry  = acc.wdata[XLEN-1:6];
                CSR_SAVE0:  n.save[0] = acc.wdata;
                CSR_SAVE1:  n.save[1] = acc.wdata;
                CSR_SAVE2:  n.save[2] = acc.wdata;
                CSR_SAVE3:  n.save[3] = acc.wdata;
                default: ;
            endcase
        end
        return n;
    endfunction

    assign csr_wr = csr_write(csr_write(csr_q, acc0_i), acc1_i);  // Slot 1 last

    always_comb begin
        csr_d       = csr_wr;
        csr_d.is_hw = intrpt_i;   // Sampled every edge
        if (event_i.excp) begin
            // Exception entry overrides the slot writes
            csr_d.era   = event_i.pc;
            csr_d.pplv  = csr_wr.plv;
            csr_d.pie   = csr_wr.ie;
            csr_d.plv   = '0;
            csr_d.ie    = 1'b0;
            csr_d.ecode = event_i.ecode;
        end else if (event_i.ertn) begin
            csr_d.plv = csr_wr.pplv;
            csr_d.ie  = csr_wr.pie;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            csr_q <= '0;
        end else begin
            csr_q <= csr_d;
        end
    end

    // Reads see the state from before the edge
    assign rdata0_o = acc0_i.re ? csr_read(csr_q, acc0_i.addr) : '0;
    assign rdata1_o = acc1_i.re ? csr_read(csr_q, acc1_i.addr) : '0;

    assign eentry_o  = {csr_q.eentry, 6'b0};
    assign era_o     = csr_q.era;
    assign has_int_o = csr_q.ie && |({csr_q.is_hw, csr_q.is_sw} & csr_q.lie);

endmodule

// File: logic/commit_ctrl.sv
`timescale 1ns/1ps

module commit_ctrl
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  commit_slot_t    slot0_i,
    input  commit_slot_t    slot1_i,
    input  logic            has_int_i,
    input  logic [XLEN-1:0] csr_rdata0_i,
    input  logic [XLEN-1:0] csr_rdata1_i,
    input  logic [XLEN-1:0] eentry_i,
    input  logic [XLEN-1:0] era_i,
    output rf_write_t       rf_wr0_o,
    output rf_write_t       rf_wr1_o,
    output csr_access_t     csr_acc0_o,
    output csr_access_t     csr_acc1_o,
    output excp_event_t     event_o,
    output trace_t          trace0_o,
    output trace_t          trace1_o,
    output redirect_t       redirect_o
);

    logic      take_int;   // Slot 0 replaced by an interrupt
    logic      s0_live;
    logic      s0_excp;
    logic      s0_ertn;
    logic      s1_live;
    logic      s1_excp;
    logic      s1_ertn;
    redirect_t redirect_d;

    function automatic rf_write_t rf_req(commit_slot_t s, logic live,
                                         logic [XLEN-1:0] csr_rdata);
        rf_write_t w;
        w.we    = live && s.rd != '0 &&
                  (s.op == OP_ALU || s.op == OP_CSRRD || s.op == OP_CSRWR);
        w.waddr = s.rd;
        w.wdata = (s.op == OP_ALU) ? s.wdata : csr_rdata;  // CSR ops return old value
        return w;
    endfunction

    function automatic csr_access_t csr_req(commit_slot_t s, logic live);
        csr_access_t a;
        a.re    = live && (s.op == OP_CSRRD || s.op == OP_CSRWR);
        a.we    = live && s.op == OP_CSRWR;
        a.addr  = s.csr_addr;
        a.wdata = s.wdata;
        return a;
    endfunction

    function automatic trace_t trace_of(commit_slot_t s, logic live, rf_write_t w);
        trace_t t;
        t.valid = live;
        t.pc    = s.pc;
        t.wen   = w.we;      // Clear for EXCP, ERTN and r0
        t.rd    = s.rd;
        t.wdata = w.wdata;
        return t;
    endfunction

    assign take_int = slot0_i.valid && has_int_i;
    assign s0_live  = slot0_i.valid && !take_int;
    assign s0_excp  = take_int || (s0_live && slot0_i.op == OP_EXCP);
    assign s0_ertn  = s0_live && slot0_i.op == OP_ERTN;

    // Anything that redirects in slot 0 squashes slot 1
    assign s1_live = slot1_i.valid && !(s0_excp || s0_ertn);
    assign s1_excp = s1_live && slot1_i.op == OP_EXCP;
    assign s1_ertn = s1_live && slot1_i.op == OP_ERTN;

    assign rf_wr0_o   = rf_req(slot0_i, s0_live, csr_rdata0_i);
    assign rf_wr1_o   = rf_req(slot1_i, s1_live, csr_rdata1_i);
    assign csr_acc0_o = csr_req(slot0_i, s0_live);
    assign csr_acc1_o = csr_req(slot1_i, s1_live);

    // The older slot owns the single event of the cycle
    always_comb begin
        event_o.excp = s0_excp || s1_excp;
        event_o.ertn = s0_ertn || s1_ertn;
        if (s0_excp || s0_ertn) begin
            event_o.pc    = slot0_i.pc;
            event_o.ecode = take_int ? ECODE_INT : slot0_i.ecode;
        end else begin
            event_o.pc    = slot1_i.pc;
            event_o.ecode = slot1_i.ecode;
        end
    end

    always_comb begin
        redirect_d.valid = event_o.excp || event_o.ertn;
        redirect_d.pc    = event_o.excp ? eentry_i : era_i;  // Pre-edge CSR values
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trace0_o   <= '0;
            trace1_o   <= '0;
            redirect_o <= '0;
        end else begin
            trace0_o   <= trace_of(slot0_i, s0_live, rf_wr0_o);
            trace1_o   <= trace_of(slot1_i, s1_live, rf_wr1_o);
            redirect_o <= redirect_d;
        end
    end

endmodule

// File: logic/core_commit_top.sv
`timescale 1ns/1ps

module core_commit_top
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  commit_slot_t       slot0_i,
    input  commit_slot_t       slot1_i,
    input  logic [NUM_HWI-1:0] intrpt_i,
    input  logic [REG_AW-1:0]  rf_raddr_i,
    output logic [XLEN-1:0]    rf_rdata_o,
    output trace_t             trace0_o,
    output trace_t             trace1_o,
    output redirect_t          redirect_o
);

    rf_write_t       rf_wr0;
    rf_write_t       rf_wr1;
    csr_access_t     csr_acc0;
    csr_access_t     csr_acc1;
    excp_event_t     excp_event;
    logic [XLEN-1:0] csr_rdata0;
    logic [XLEN-1:0] csr_rdata1;
    logic [XLEN-1:0] csr_eentry;
    logic [XLEN-1:0] csr_era;
    logic            has_int;

    commit_ctrl i_commit_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .slot0_i      (slot0_i),
        .slot1_i      (slot1_i),
        .has_int_i    (has_int),
        .csr_rdata0_i (csr_rdata0),
        .csr_rdata1_i (csr_rdata1),
        .eentry_i     (csr_eentry),
        .era_i        (csr_era),
        .rf_wr0_o     (rf_wr0),
        .rf_wr1_o     (rf_wr1),
        .csr_acc0_o   (csr_acc0),
        .csr_acc1_o   (csr_acc1),
        .event_o      (excp_event),
        .trace0_o     (trace0_o),
        .trace1_o     (trace1_o),
        .redirect_o   (redirect_o)
    );

    regfile i_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr0_i   (rf_wr0),
        .wr1_i   (rf_wr1),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

    csr_file i_csr_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .acc0_i    (csr_acc0),
        .acc1_i    (csr_acc1),
        .event_i   (excp_event),
        .intrpt_i  (intrpt_i),
        .rdata0_o  (csr_rdata0),
        .rdata1_o  (csr_rdata1),
        .eentry_o  (csr_eentry),
        .era_o     (csr_era),
        .has_int_o (has_int)
    );

endmodule

// File: dv/tb_core_commit.sv
`timescale 1ns/1ps

module tb_core_commit
    import core_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int MAX_VEC    = 64;
    localparam int NUM_FIELDS = 30;
    localparam int MAX_ID     = 16;

    logic               clk;
    logic               rst_n_i;
    commit_slot_t       slot0_i;
    commit_slot_t       slot1_i;
    logic [NUM_HWI-1:0] intrpt_i;
    logic [REG_AW-1:0]  rf_raddr_i;
    logic [XLEN-1:0]    rf_rdata_o;
    trace_t             trace0_o;
    trace_t             trace1_o;
    redirect_t          redirect_o;

    // One entry per vector line
    int                 vec_id     [MAX_VEC];
    commit_slot_t       vec_slot0  [MAX_VEC];
    commit_slot_t       vec_slot1  [MAX_VEC];
    logic [NUM_HWI-1:0] vec_intrpt [MAX_VEC];
    logic [REG_AW-1:0]  vec_raddr  [MAX_VEC];
    trace_t             vec_trace0 [MAX_VEC];
    trace_t             vec_trace1 [MAX_VEC];
    redirect_t          vec_redir  [MAX_VEC];
    logic [XLEN-1:0]    vec_rdata  [MAX_VEC];

    int n_vec;
    int test_errs [MAX_ID];
    int total_errs;
    int tests_run;
    int tests_failed;
    int cycle_cnt;
    int cycle_limit;

    core_commit_top i_core_commit_top (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .slot0_i    (slot0_i),
        .slot1_i    (slot1_i),
        .intrpt_i   (intrpt_i),
        .rf_raddr_i (rf_raddr_i),
        .rf_rdata_o (rf_rdata_o),
        .trace0_o   (trace0_o),
        .trace1_o   (trace1_o),
        .redirect_o (redirect_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Run limit armed once the vectors are loaded
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic commit_slot_t make_slot(logic [XLEN-1:0] f[NUM_FIELDS], int b);
        commit_slot_t s;
        s.valid    = f[b][0];
        s.pc       = f[b+1];
        s.op       = commit_op_e'(f[b+2][2:0]);
        s.rd       = f[b+3][REG_AW-1:0];
        s.wdata    = f[b+4];
        s.csr_addr = f[b+5][CSR_AW-1:0];
        s.ecode    = f[b+6][ECODE_W-1:0];
        return s;
    endfunction

    function automatic trace_t make_trace(logic [XLEN-1:0] f[NUM_FIELDS], int b);
        trace_t t;
        t.valid = f[b][0];
        t.pc    = f[b+1];
        t.wen   = f[b+2][0];
        t.rd    = f[b+3][REG_AW-1:0];
        t.wdata = f[b+4];
        return t;
    endfunction

    task automatic load_vectors();
        int              fd;
        int              cnt;
        string           line;
        logic [XLEN-1:0] f [NUM_FIELDS];
        n_vec = 0;
        fd = $fopen("dv/commit_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file");
            total_errs++;
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                cnt = $sscanf(line,
                    "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                    f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27], f[28], f[29]);
                if (cnt != NUM_FIELDS) begin
                    $display("Malformed vector line: %s", line);
                    total_errs++;
                    continue;
                end
                vec_id[n_vec]     = f[0];
                vec_slot0[n_vec]  = make_slot(f, 1);
                vec_slot1[n_vec]  = make_slot(f, 8);
                vec_intrpt[n_vec] = f[15][NUM_HWI-1:0];
                vec_raddr[n_vec]  = f[16][REG_AW-1:0];
                vec_trace0[n_vec] = make_trace(f, 17);
                vec_trace1[n_vec] = make_trace(f, 22);
                vec_redir[n_vec]  = {f[27][0], f[28]};
                vec_rdata[n_vec]  = f[29];
                n_vec++;
            end
            $fclose(fd);
        end
    endtask

    // Only valid slots are compared in full
    // Trace wdata matters only when wen is set
    task automatic check_trace(string name, trace_t act, trace_t exp, int id);
        logic bad;
        bad = act.valid !== exp.valid;
        if (exp.valid) begin
            bad = bad || act.pc !== exp.pc || act.wen !== exp.wen || act.rd !== exp.rd;
            if (exp.wen) begin
                bad = bad || act.wdata !== exp.wdata;
            end
        end
        if (bad) begin
            $display("Error %0t %s expected %h actual %h", $time, name, exp, act);
            test_errs[id]++;
        end
    endtask

    task automatic check_redirect(redirect_t act, redirect_t exp, int id);
        if (act.valid !== exp.valid || (exp.valid && act.pc !== exp.pc)) begin
            $display("Error %0t redirect_o expected %h actual %h", $time, exp, act);
            test_errs[id]++;
        end
    endtask

    task automatic check_rdata(logic [XLEN-1:0] act, logic [XLEN-1:0] exp, int id);
        if (act !== exp) begin
            $display("Error %0t rf_rdata_o expected %h actual %h", $time, exp, act);
            test_errs[id]++;
        end
    endtask

    task automatic report_test(int id);
        tests_run++;
        total_errs += test_errs[id];
        if (test_errs[id] != 0) begin
            tests_failed++;
            $display("Test %0d failed with %0d errors", id, test_errs[id]);
        end else begin
            $display("Test %0d passed", id);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        slot0_i     = '0;
        slot1_i     = '0;
        intrpt_i    = '0;
        rf_raddr_i  = '0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        total_errs  = 0;
        tests_run   = 0;
        tests_failed = 0;
        for (int i = 0; i < MAX_ID; i++) begin
            test_errs[i] = 0;
        end
        load_vectors();
        cycle_limit = n_vec + 20;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int k = 0; k <= n_vec; k++) begin
            @(posedge clk);
            if (k < n_vec) begin
                slot0_i    <= vec_slot0[k];
                slot1_i    <= vec_slot1[k];
                intrpt_i   <= vec_intrpt[k];
                rf_raddr_i <= vec_raddr[k];
            end else begin
                slot0_i    <= '0;
                slot1_i    <= '0;
                intrpt_i   <= '0;
                rf_raddr_i <= '0;
            end
            #(CLK_PERIOD - 1);
            if (k < n_vec) begin
                check_rdata(rf_rdata_o, vec_rdata[k], vec_id[k]);
            end
            // Registered outputs lag their inputs by one edge
            if (k > 0) begin
                check_trace("trace0_o", trace0_o, vec_trace0[k-1], vec_id[k-1]);
                check_trace("trace1_o", trace1_o, vec_trace1[k-1], vec_id[k-1]);
                check_redirect(redirect_o, vec_redir[k-1], vec_id[k-1]);
                if (k == n_vec || vec_id[k] != vec_id[k-1]) begin
                    report_test(vec_id[k-1]);
                end
            end
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0 && n_vec > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/commit_vectors.txt
# id | slot0: v pc op rd wdata csr ecode | slot1: same | intrpt raddr
# exp trace0: v pc wen rd wdata | exp trace1: same | exp redirect: v pc | exp rdata
1 1 100 0 1 11111111 0 0 1 104 0 2 22222222 0 0 0 0 1 100 1 1 11111111 1 104 1 2 22222222 0 0 0
1 1 108 0 3 aaaa 0 0 1 10c 0 3 bbbb 0 0 0 1 1 108 1 3 aaaa 1 10c 1 3 bbbb 0 0 11111111
1 1 110 0 0 dead 0 0 0 0 0 0 0 0 0 0 3 1 110 0 0 0 0 0 0 0 0 0 0 bbbb
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 1 200 2 4 5a5a5a5a 30 0 1 204 1 5 0 30 0 0 2 1 200 1 4 0 1 204 1 5 0 0 0 22222222
2 1 208 1 6 0 30 0 1 20c 1 7 0 7 0 0 4 1 208 1 6 5a5a5a5a 1 20c 1 7 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 0 0 0 0 0 5a5a5a5a
3 1 300 2 0 1c000040 c 0 1 304 2 0 7 0 0 0 7 1 300 0 0 0 1 304 0 0 0 0 0 0
3 1 310 3 0 0 0 d 1 314 0 8 ffff 0 0 0 0 1 310 0 0 0 0 0 0 0 0 1 1c000040 0
3 1 1c000040 1 9 0 6 0 1 1c000044 1 a 0 5 0 0 8 1 1c000040 1 9 310 1 1c000044 1 a d0000 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 0 0 0 0 0 0 0 0 0 0 0 0 310
4 1 1c000048 4 0 0 0 0 1 1c00004c 0 b 1 0 0 0 a 1 1c000048 0 0 0 0 0 0 0 0 1 310 d0000
4 1 314 1 c 0 0 0 1 318 1 d 0 1 0 0 b 1 314 1 c 7 1 318 1 d 7 0 0 0
5 1 400 2 0 4 4 0 0 0 0 0 0 0 0 0 c 1 400 0 0 0 0 0 0 0 0 0 0 7
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 1 500 0 e 1234 0 0 1 504 0 f 5678 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 1c000040 0
5 1 1c000040 1 10 0 6 0 1 1c000044 1 11 0 5 0 0 e 1 1c000040 1 10 500 1 1c000044 1 11 4 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 500
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0 0 0 0 0 0 0 0 4

// File: list.f
logic/core_pkg.sv
logic/regfile.sv
logic/csr_file.sv
logic/commit_ctrl.sv
logic/core_commit_top.sv
dv/tb_core_commit.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_core_commit
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^STATUS: PASS" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
